// File: design/lcd_pkg.sv
package lcd_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    typedef logic [6:0]  i2c_addr_t;
    typedef logic [7:0]  lcd_byte_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [15:0] usec_count_t;
    typedef logic [2:0]  bit_index_t;

    ////////////////////////////////////////
    // state machines
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        M_IDLE,
        M_START,
        M_SEND_ADDR,
        M_READ_ACK,
        M_SEND_DATA,
        M_SCL_STOP,
        M_STOP_HOLD
    } master_state_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_HIGH_OFF,
        S_HIGH_ON,
        S_LOW_OFF,
        S_LOW_ON,
        S_FINAL_OFF
    } seq_state_t;

    // expander byte layout, nibble sits in [7:4]
    localparam int EXP_BACKLIGHT = 3;
    localparam int EXP_ENABLE    = 2;
    localparam int EXP_RW        = 1;
    localparam int EXP_RS        = 0;

endpackage

// File: design/usec_tick.sv
`timescale 1ns/1ps

module usec_tick #(
    parameter int CLK_PER_USEC = 100
) (
    input  logic clk,
    input  logic reset_p,
    output logic usec_pulse
);

    localparam int CNT_W = (CLK_PER_USEC > 1) ? $clog2(CLK_PER_USEC) : 1;

    logic [CNT_W-1:0] clk_cnt;

    // one pulse per wrap of the divider
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            clk_cnt    <= '0;
            usec_pulse <= 1'b0;
        end else if (clk_cnt == CNT_W'(CLK_PER_USEC - 1)) begin
            clk_cnt    <= '0;
            usec_pulse <= 1'b1;
        end else begin
            clk_cnt    <= clk_cnt + 1'b1;
            usec_pulse <= 1'b0;
        end
    end

endmodule

// File: design/i2c_write_master.sv
`timescale 1ns/1ps

module i2c_write_master
    import lcd_pkg::*;
#(
    parameter int SCL_HALF_USEC = 5
) (
    input  logic      clk,
    input  logic      reset_p,
    input  logic      usec_pulse,
    input  i2c_addr_t addr,
    input  logic      frame_start,
    input  lcd_byte_t frame_data,
    output logic      scl,
    output logic      sda_oe
);

    // sda held low this long after scl goes high at the stop
    localparam int STOP_USEC = 3;
    localparam int HALF_W    = (SCL_HALF_USEC > 1) ? $clog2(SCL_HALF_USEC) : 1;

    master_state_t    state;
    logic [HALF_W-1:0] half_cnt;
    logic [1:0]        stop_cnt;
    logic              scl_en;
    logic              scl_q;
    logic              scl_rise;
    logic              scl_fall;
    bit_index_t        bit_idx;
    logic              second_ack;
    lcd_byte_t         addr_byte;

    ////////////////////////////////////////
    // scl generation
    ////////////////////////////////////////

    assign scl_en = (state == M_SEND_ADDR) || (state == M_READ_ACK) ||
                    (state == M_SEND_DATA) || (state == M_SCL_STOP);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            half_cnt <= '0;
            scl      <= 1'b1;
        end else if (!scl_en) begin
            half_cnt <= '0;
            scl      <= 1'b1;
        end else if (usec_pulse) begin
            if (half_cnt == HALF_W'(SCL_HALF_USEC - 1)) begin
                half_cnt <= '0;
                scl      <= ~scl;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // edges seen one cycle late, data moves while scl is low
    assign scl_rise = scl & ~scl_q;
    assign scl_fall = ~scl & scl_q;

    // address and write bit of zero, taken at the start of the frame
    always_ff @(posedge clk) begin
        if (state == M_IDLE && frame_start) begin
            addr_byte <= {addr, 1'b0};
        end
    end

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state      <= M_IDLE;
            sda_oe     <= 1'b0;
            scl_q      <= 1'b1;
            bit_idx    <= 3'd7;
            second_ack <= 1'b0;
            stop_cnt   <= '0;
        end else begin
            scl_q <= scl;
            case (state)
                M_IDLE: begin
                    sda_oe     <= 1'b0;
                    bit_idx    <= 3'd7;
                    second_ack <= 1'b0;
                    stop_cnt   <= '0;
                    if (frame_start) begin
                        state <= M_START;
                    end
                end
                M_START: begin
                    // sda falls while scl is still high
                    sda_oe <= 1'b1;
                    state  <= M_SEND_ADDR;
                end
                M_SEND_ADDR: begin
                    if (scl_fall) begin
                        sda_oe <= ~addr_byte[bit_idx];
                    end
                    if (scl_rise) begin
                        bit_idx <= bit_idx - 1'b1;
                        if (bit_idx == 3'd0) begin
                            state <= M_READ_ACK;
                        end
                    end
                end
                M_READ_ACK: begin
                    // line released for the target, ack is not checked
                    if (scl_fall) begin
                        sda_oe <= 1'b0;
                    end
                    if (scl_rise) begin
                        if (second_ack) begin
                            state <= M_SCL_STOP;
                        end else begin
                            second_ack <= 1'b1;
                            state      <= M_SEND_DATA;
                        end
                    end
                end
                M_SEND_DATA: begin
                    if (scl_fall) begin
                        sda_oe <= ~frame_data[bit_idx];
                    end
                    if (scl_rise) begin
                        bit_idx <= bit_idx - 1'b1;
                        if (bit_idx == 3'd0) begin
                            state <= M_READ_ACK;
                        end
                    end
                end
                M_SCL_STOP: begin
                    if (scl_fall) begin
                        sda_oe <= 1'b1;
                    end
                    if (scl_rise) begin
                        state <= M_STOP_HOLD;
                    end
                end
                M_STOP_HOLD: begin
                    if (usec_pulse) begin
                        if (stop_cnt == 2'(STOP_USEC - 1)) begin
                            // sda rises with scl high, the stop condition
                            sda_oe <= 1'b0;
                            state  <= M_IDLE;
                        end else begin
                            stop_cnt <= stop_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/lcd_nibble_sequencer.sv
`timescale 1ns/1ps

module lcd_nibble_sequencer
    import lcd_pkg::*;
#(
    parameter int STEP_USEC = 200
) (
    input  logic      clk,
    input  logic      reset_p,
    input  logic      usec_pulse,
    input  logic      send,
    input  logic      rs,
    input  lcd_byte_t lcd_byte,
    output logic      busy,
    output logic      frame_start,
    output lcd_byte_t frame_data
);

    seq_state_t  state;
    seq_state_t  next_slot;
    usec_count_t usec_cnt;
    logic        send_q;
    logic        send_rise;
    logic        accept;
    lcd_byte_t   byte_q;
    logic        rs_q;
    nibble_t     nibble;
    logic        enable;

    assign send_rise = send & ~send_q;
    // edges that arrive while busy are dropped
    assign accept    = send_rise && (state == S_IDLE);
    assign busy      = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (accept) begin
            byte_q <= lcd_byte;
            rs_q   <= rs;
        end
    end

    ////////////////////////////////////////
    // slot order
    ////////////////////////////////////////

    always_comb begin
        case (state)
            S_HIGH_OFF: next_slot = S_HIGH_ON;
            S_HIGH_ON:  next_slot = S_LOW_OFF;
            S_LOW_OFF:  next_slot = S_LOW_ON;
            S_LOW_ON:   next_slot = S_FINAL_OFF;
            default:    next_slot = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state       <= S_IDLE;
            send_q      <= 1'b0;
            usec_cnt    <= '0;
            frame_start <= 1'b0;
        end else begin
            send_q      <= send;
            frame_start <= 1'b0;
            if (state == S_IDLE) begin
                usec_cnt <= '0;
                if (accept) begin
                    state       <= S_HIGH_OFF;
                    frame_start <= 1'b1;
                end
            end else if (usec_pulse) begin
                if (usec_cnt == usec_count_t'(STEP_USEC - 1)) begin
                    usec_cnt    <= '0;
                    state       <= next_slot;
                    frame_start <= (next_slot != S_IDLE);
                end else begin
                    usec_cnt <= usec_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // expander byte
    ////////////////////////////////////////

    assign nibble = (state == S_HIGH_OFF || state == S_HIGH_ON) ? byte_q[7:4] : byte_q[3:0];
    assign enable = (state == S_HIGH_ON || state == S_LOW_ON);

    // backlight always on, write only
    always_comb begin
        frame_data                = '0;
        frame_data[7:4]           = nibble;
        frame_data[EXP_BACKLIGHT] = 1'b1;
        frame_data[EXP_ENABLE]    = enable;
        frame_data[EXP_RW]        = 1'b0;
        frame_data[EXP_RS]        = rs_q;
    end

endmodule

// File: design/i2c_lcd_top.sv
`timescale 1ns/1ps

module i2c_lcd_top
    import lcd_pkg::*;
#(
    parameter int CLK_PER_USEC  = 100,
    parameter int SCL_HALF_USEC = 5,
    parameter int STEP_USEC     = 200
) (
    input  logic      clk,
    input  logic      reset_p,
    input  logic      send,
    input  logic      rs,
    input  lcd_byte_t lcd_byte,
    input  i2c_addr_t addr,
    output logic      busy,
    output logic      scl,
    output logic      sda_oe
);

    logic      usec_pulse;
    logic      frame_start;
    lcd_byte_t frame_data;

    // shared time base
    usec_tick #(
        .CLK_PER_USEC (CLK_PER_USEC)
    ) u_usec_tick (
        .clk        (clk),
        .reset_p    (reset_p),
        .usec_pulse (usec_pulse)
    );

    lcd_nibble_sequencer #(
        .STEP_USEC (STEP_USEC)
    ) u_sequencer (
        .clk         (clk),
        .reset_p     (reset_p),
        .usec_pulse  (usec_pulse),
        .send        (send),
        .rs          (rs),
        .lcd_byte    (lcd_byte),
        .busy        (busy),
        .frame_start (frame_start),
        .frame_data  (frame_data)
    );

    i2c_write_master #(
        .SCL_HALF_USEC (SCL_HALF_USEC)
    ) u_master (
        .clk         (clk),
        .reset_p     (reset_p),
        .usec_pulse  (usec_pulse),
        .addr        (addr),
        .frame_start (frame_start),
        .frame_data  (frame_data),
        .scl         (scl),
        .sda_oe      (sda_oe)
    );

endmodule

// File: test/i2c_lcd_checker.sv
`timescale 1ns/1ps

module i2c_lcd_checker (
    input logic clk,
    input logic reset_p,
    input logic busy,
    input logic scl,
    input logic sda_oe
);

    ////////////////////////////////////////
    // bus parked between transfers
    ////////////////////////////////////////

    scl_idle_high: assert property (@(posedge clk) disable iff (reset_p) !busy |-> scl)
        else $error("scl low while busy is low");

    sda_idle_released: assert property (@(posedge clk) disable iff (reset_p) !busy |-> !sda_oe)
        else $error("sda pulled low while busy is low");

    // first cycle out of reset
    busy_low_after_reset: assert property (@(posedge clk) $fell(reset_p) |-> !busy)
        else $error("busy high in the cycle after reset release");

endmodule

bind i2c_lcd_top i2c_lcd_checker u_checker (
    .clk     (clk),
    .reset_p (reset_p),
    .busy    (busy),
    .scl     (scl),
    .sda_oe  (sda_oe)
);

// File: test/tb_i2c_lcd.sv
`timescale 1ns/1ps

module tb_i2c_lcd
    import lcd_pkg::*;
();

    localparam int CLK_PER_USEC  = 4;
    localparam int SCL_HALF_USEC = 5;
    localparam int STEP_USEC     = 200;
    localparam int CLK_PERIOD_NS = 10;
    // transfers started over the whole run
    localparam int N_TRANSFERS   = 14;
    localparam int IDLE_LIMIT    = 6 * STEP_USEC * CLK_PER_USEC;
    localparam int TIMEOUT_NS    = (N_TRANSFERS + 2) * IDLE_LIMIT * CLK_PERIOD_NS;

    logic      clk;
    logic      reset_p;
    logic      send;
    logic      rs;
    lcd_byte_t lcd_byte;
    i2c_addr_t addr;
    logic      busy;
    logic      scl;
    logic      sda_oe;

    int          err_count;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lcg_state;

    // bus monitor
    logic        scl_prev;
    logic        sda_prev;
    logic        sda_now;
    logic        in_frame;
    logic        pending;
    logic        bit_held;
    logic [17:0] frame_bits;
    int          pulse_cnt;
    lcd_byte_t   mon_addr[$];
    lcd_byte_t   mon_data[$];
    logic        mon_ack1[$];
    logic        mon_ack2[$];
    int          mon_pulses[$];

    i2c_lcd_top #(
        .CLK_PER_USEC  (CLK_PER_USEC),
        .SCL_HALF_USEC (SCL_HALF_USEC),
        .STEP_USEC     (STEP_USEC)
    ) u_dut (
        .clk      (clk),
        .reset_p  (reset_p),
        .send     (send),
        .rs       (rs),
        .lcd_byte (lcd_byte),
        .addr     (addr),
        .busy     (busy),
        .scl      (scl),
        .sda_oe   (sda_oe)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////
    // bus monitor
    ////////////////////////////////////////

    // a clock pulse counts when scl falls after a rise in the frame
    always @(negedge clk) begin
        sda_now = ~sda_oe;
        if (reset_p) begin
            in_frame   = 1'b0;
            pending    = 1'b1;
            bit_held   = 1'b0;
            frame_bits = '0;
            pulse_cnt  = 0;
        end else if (scl && scl_prev && sda_prev && !sda_now) begin
            in_frame   = 1'b1;
            bit_held   = 1'b0;
            frame_bits = '0;
            pulse_cnt  = 0;
        end else if (in_frame && scl && scl_prev && !sda_prev && sda_now) begin
            in_frame = 1'b0;
            mon_addr.push_back(frame_bits[17:10]);
            mon_ack1.push_back(~frame_bits[9]);
            mon_data.push_back(frame_bits[8:1]);
            mon_ack2.push_back(~frame_bits[0]);
            mon_pulses.push_back(pulse_cnt);
        end else if (in_frame && scl && !scl_prev) begin
            pending  = sda_now;
            bit_held = 1'b1;
        end else if (in_frame && bit_held && !scl && scl_prev) begin
            frame_bits = {frame_bits[16:0], pending};
            bit_held   = 1'b0;
            pulse_cnt++;
        end
        scl_prev = scl;
        sda_prev = sda_now;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // nibble over backlight, enable, write bit and rs
    function automatic lcd_byte_t expander_byte(input nibble_t nib, input logic en,
                                                input logic r);
        return {nib, 1'b1, en, 1'b0, r};
    endfunction

    task automatic expect_byte(input string name, input lcd_byte_t got, input lcd_byte_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%02h expected 0x%02h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic verify_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic score_frames(input int first, input i2c_addr_t a, input lcd_byte_t b,
                                input logic r);
        lcd_byte_t exp_data[5];
        int        got;
        int        i;
        exp_data[0] = expander_byte(b[7:4], 1'b0, r);
        exp_data[1] = expander_byte(b[7:4], 1'b1, r);
        exp_data[2] = expander_byte(b[3:0], 1'b0, r);
        exp_data[3] = expander_byte(b[3:0], 1'b1, r);
        exp_data[4] = expander_byte(b[3:0], 1'b0, r);
        got = mon_addr.size() - first;
        if (got != 5) begin
            $display("byte 0x%02h gave %0d frames instead of 5", b, got);
            err_count++;
        end
        for (i = 0; i < 5 && i < got; i++) begin
            expect_byte($sformatf("frame%0d addr_byte", i), mon_addr[first + i], {a, 1'b0});
            expect_byte($sformatf("frame%0d data_byte", i), mon_data[first + i], exp_data[i]);
            verify_bit($sformatf("frame%0d ack1 sda_oe", i), mon_ack1[first + i], 1'b0);
            verify_bit($sformatf("frame%0d ack2 sda_oe", i), mon_ack2[first + i], 1'b0);
            if (mon_pulses[first + i] != 18) begin
                $display("frame %0d had %0d scl pulses instead of 18", i, mon_pulses[first + i]);
                err_count++;
            end
        end
    endtask

    task automatic start_transfer(input lcd_byte_t b, input logic r);
        @(posedge clk);
        lcd_byte <= b;
        rs       <= r;
        send     <= 1'b1;
        // edge taken here, busy follows
        @(posedge clk);
        @(negedge clk);
        verify_bit("busy", busy, 1'b1);
        @(posedge clk);
        send <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== 1'b0 && n < IDLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("busy stayed high for %0d cycles", IDLE_LIMIT);
            err_count++;
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic transfer_checked(input i2c_addr_t a, input lcd_byte_t b, input logic r);
        int first;
        first = mon_addr.size();
        start_transfer(b, r);
        wait_idle();
        verify_bit("busy", busy, 1'b0);
        score_frames(first, a, b, r);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d check(s) failed", name, err_count - errs_before);
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic reset_state();
        int errs;
        errs = err_count;
        @(negedge clk);
        verify_bit("busy", busy, 1'b0);
        verify_bit("scl", scl, 1'b1);
        verify_bit("sda_oe", sda_oe, 1'b0);
        report_test("reset_state", errs);
    endtask

    task automatic random_data();
        int        errs;
        int        k;
        lcd_byte_t b;
        errs = err_count;
        for (k = 0; k < 10; k++) begin
            lcg_state = lcg_next(lcg_state);
            b         = lcg_state[23:16];
            transfer_checked(addr, b, 1'b1);
        end
        report_test("random_data", errs);
    endtask

    task automatic ignored_send();
        int errs;
        int first;
        errs  = err_count;
        first = mon_addr.size();
        start_transfer(8'h5a, 1'b1);
        repeat (20) @(posedge clk);
        lcd_byte <= 8'ha5;
        rs       <= 1'b0;
        send     <= 1'b1;
        repeat (2) @(posedge clk);
        send <= 1'b0;
        wait_idle();
        // dropped edge must not start a late transfer
        repeat (STEP_USEC * CLK_PER_USEC) @(negedge clk);
        verify_bit("busy", busy, 1'b0);
        score_frames(first, addr, 8'h5a, 1'b1);
        report_test("ignored_send", errs);
    endtask

    task automatic address_change();
        int errs;
        errs = err_count;
        @(posedge clk);
        addr <= 7'h3f;
        transfer_checked(7'h3f, 8'hc7, 1'b1);
        report_test("address_change", errs);
    endtask

    initial begin
        int errs;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        lcg_state    = 32'd55;
        reset_p  <= 1'b1;
        send     <= 1'b0;
        rs       <= 1'b0;
        lcd_byte <= '0;
        addr     <= 7'h27;
        repeat (10) @(posedge clk);
        reset_p <= 1'b0;
        repeat (3) @(posedge clk);
        reset_state();
        errs = err_count;
        transfer_checked(addr, 8'h28, 1'b0);
        report_test("command_byte", errs);
        random_data();
        ignored_send();
        // all-zero data keeps sda low right before each ack slot
        errs = err_count;
        transfer_checked(addr, 8'h00, 1'b0);
        report_test("ack_release", errs);
        address_change();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/lcd_pkg.sv
design/usec_tick.sv
design/i2c_write_master.sv
design/lcd_nibble_sequencer.sv
design/i2c_lcd_top.sv
test/i2c_lcd_checker.sv
test/tb_i2c_lcd.sv

// File: run_sim.sh
#!/bin/sh
# build and run the I2C LCD testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_i2c_lcd \
    -o tb_i2c_lcd

./obj_dir/tb_i2c_lcd | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
